/* snake_pkg.sv */
package snake_pkg;

    // Segment names double as bit positions in a segs_t mask
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_e;

    typedef enum logic [1:0] {
        DIR_RIGHT = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_DOWN  = 2'd3
    } dir_e;

    typedef enum logic [1:0] {
        MODE_INIT = 2'd0,
        MODE_MOVE = 2'd1,
        MODE_FALL = 2'd2
    } mode_e;

    // Bit n is segment n with A in bit 0
    typedef logic [6:0] segs_t;

endpackage

/* key_pulse.sv */
module key_pulse #(
    parameter int unsigned DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic key,
    output logic pulse
);

    logic [DEBOUNCE_LEN-1:0] history;
    logic                    level;
    logic                    level_q;

    // Stable only when every sample in the window is high
    assign level = &history;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history <= '0;
            level_q <= 1'b0;
            pulse   <= 1'b0;
        end else begin
            history <= (history << 1) | DEBOUNCE_LEN'(key);
            level_q <= level;
            // Rising edge of the debounced level
            pulse   <= level & ~level_q;
        end
    end

endmodule

/* game_ctrl.sv */
module game_ctrl #(
    parameter int unsigned TICK_CYCLES = 2**26,
    parameter int unsigned INIT_TICKS  = 3,
    parameter int unsigned FALL_TICKS  = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              down_pulse,
    input  logic              trail_empty,
    output snake_pkg::mode_e  mode,
    output logic              init,
    output logic              move,
    output logic              fall
);

    import snake_pkg::*;

    localparam int unsigned INIT_CYCLES = INIT_TICKS * TICK_CYCLES;
    localparam int unsigned FALL_CYCLES = FALL_TICKS * TICK_CYCLES;
    localparam int unsigned MAX_CYCLES  =
        (INIT_CYCLES > FALL_CYCLES) ? INIT_CYCLES : FALL_CYCLES;
    localparam int CNT_W = $clog2(MAX_CYCLES + 1);

    localparam logic [CNT_W-1:0] INIT_LAST = CNT_W'(INIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] FALL_LAST = CNT_W'(FALL_CYCLES - 1);

    mode_e            mode_next;
    logic [CNT_W-1:0] cnt;
    logic             counting;
    logic             init_done;
    logic             fall_done;

    // Init always counts, fall only once the trail has emptied
    assign counting  = (mode == MODE_INIT) || ((mode == MODE_FALL) && trail_empty);
    assign init_done = (mode == MODE_INIT) && (cnt == INIT_LAST);
    assign fall_done = (mode == MODE_FALL) && trail_empty && (cnt == FALL_LAST);

    always_comb begin
        mode_next = mode;
        case (mode)
            MODE_INIT: begin
                if (init_done) begin
                    mode_next = MODE_MOVE;
                end
            end
            MODE_MOVE: begin
                if (down_pulse) begin
                    mode_next = MODE_FALL;
                end
            end
            MODE_FALL: begin
                if (fall_done) begin
                    mode_next = MODE_INIT;
                end
            end
            default: begin
                mode_next = MODE_INIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= MODE_INIT;
            cnt  <= '0;
        end else begin
            mode <= mode_next;
            // Restart on every mode change
            if (mode_next != mode) begin
                cnt <= '0;
            end else if (counting) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

    assign init = (mode == MODE_INIT);
    assign move = (mode == MODE_MOVE);
    assign fall = (mode == MODE_FALL);

endmodule

/* segment_walker.sv */
module segment_walker (
    input  logic              clk,
    input  logic              rst,
    input  snake_pkg::mode_e  mode,
    input  logic              right_pulse,
    input  logic              left_pulse,
    input  logic              up_pulse,
    output logic              trail_empty,
    output snake_pkg::segs_t  display
);

    import snake_pkg::*;

    localparam segs_t SEGS_ALL = 7'h7f;

    seg_e  cur_seg;
    dir_e  head;
    segs_t trail;
    seg_e  nxt_seg;
    dir_e  nxt_head;
    segs_t cur_mask;
    segs_t lit;

    assign cur_mask    = segs_t'(7'd1) << cur_seg;
    assign trail_empty = (trail == '0);

    // First matching walk table row wins
    always_comb begin
        nxt_seg  = cur_seg;
        nxt_head = head;
        case (cur_seg)
            SEG_A: begin
                if (head == DIR_RIGHT && right_pulse) begin
                    nxt_seg  = SEG_B;
                    nxt_head = DIR_DOWN;
                end else if (head == DIR_LEFT && left_pulse) begin
                    nxt_seg  = SEG_F;
                    nxt_head = DIR_DOWN;
                end
            end
            SEG_B: begin
                if (head == DIR_UP && left_pulse) begin
                    nxt_seg  = SEG_A;
                    nxt_head = DIR_LEFT;
                end else if (head == DIR_DOWN && right_pulse) begin
                    nxt_seg  = SEG_G;
                    nxt_head = DIR_LEFT;
                end else if (head == DIR_DOWN && up_pulse) begin
                    nxt_seg  = SEG_C;
                    nxt_head = DIR_DOWN;
                end
            end
            SEG_C: begin
                if (head == DIR_UP && left_pulse) begin
                    nxt_seg  = SEG_G;
                    nxt_head = DIR_LEFT;
                end else if (head == DIR_UP && up_pulse) begin
                    nxt_seg  = SEG_B;
                    nxt_head = DIR_UP;
                end else if (head == DIR_DOWN && right_pulse) begin
                    nxt_seg  = SEG_D;
                    nxt_head = DIR_DOWN;
                end
            end
            SEG_D: begin
                if (head == DIR_RIGHT && left_pulse) begin
                    nxt_seg  = SEG_C;
                    nxt_head = DIR_UP;
                end else if (head == DIR_LEFT && right_pulse) begin
                    nxt_seg  = SEG_E;
                    nxt_head = DIR_UP;
                end
            end
            SEG_E: begin
                if (head == DIR_UP && right_pulse) begin
                    nxt_seg  = SEG_G;
                    nxt_head = DIR_RIGHT;
                end else if (head == DIR_UP && up_pulse) begin
                    nxt_seg  = SEG_F;
                    nxt_head = DIR_UP;
                end else if (head == DIR_DOWN && left_pulse) begin
                    nxt_seg  = SEG_D;
                    nxt_head = DIR_RIGHT;
                end
            end
            SEG_F: begin
                if (head == DIR_UP && right_pulse) begin
                    nxt_seg  = SEG_A;
                    nxt_head = DIR_RIGHT;
                end else if (head == DIR_DOWN && left_pulse) begin
                    nxt_seg  = SEG_G;
                    nxt_head = DIR_RIGHT;
                end
            end
            SEG_G: begin
                if (head == DIR_RIGHT && left_pulse) begin
                    nxt_seg  = SEG_B;
                    nxt_head = DIR_UP;
                end else if (head == DIR_RIGHT && right_pulse) begin
                    nxt_seg  = SEG_C;
                    nxt_head = DIR_DOWN;
                end else if (head == DIR_LEFT && left_pulse) begin
                    nxt_seg  = SEG_E;
                    nxt_head = DIR_DOWN;
                end else if (head == DIR_LEFT && right_pulse) begin
                    nxt_seg  = SEG_F;
                    nxt_head = DIR_UP;
                end
            end
            default: begin
                nxt_seg  = SEG_G;
                nxt_head = DIR_LEFT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_seg <= SEG_G;
            head    <= DIR_LEFT;
            trail   <= SEGS_ALL;
        end else begin
            case (mode)
                MODE_MOVE: begin
                    cur_seg <= nxt_seg;
                    head    <= nxt_head;
                    trail   <= SEGS_ALL;
                end
                MODE_FALL: begin
                    cur_seg <= nxt_seg;
                    head    <= nxt_head;
                    trail   <= trail & ~cur_mask;
                end
                default: begin
                    cur_seg <= SEG_G;
                    head    <= DIR_LEFT;
                    trail   <= SEGS_ALL;
                end
            endcase
        end
    end

    // Active low with the walker alone lit outside fall
    assign lit     = (mode == MODE_FALL) ? trail : cur_mask;
    assign display = ~lit;

endmodule

/* snake_top.sv */
module snake_top #(
    parameter int unsigned TICK_CYCLES  = 2**26,
    parameter int unsigned INIT_TICKS   = 3,
    parameter int unsigned FALL_TICKS   = 1,
    parameter int unsigned DEBOUNCE_LEN = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              key_right,
    input  logic              key_left,
    input  logic              key_up,
    input  logic              key_down,
    output snake_pkg::segs_t  display,
    output logic              init,
    output logic              move,
    output logic              fall
);

    import snake_pkg::*;

    logic  right_pulse;
    logic  left_pulse;
    logic  up_pulse;
    logic  down_pulse;
    logic  trail_empty;
    mode_e mode;

    // One debouncer per push button
    key_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_key_right (
        .clk   (clk),
        .rst   (rst),
        .key   (key_right),
        .pulse (right_pulse)
    );

    key_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_key_left (
        .clk   (clk),
        .rst   (rst),
        .key   (key_left),
        .pulse (left_pulse)
    );

    key_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_key_up (
        .clk   (clk),
        .rst   (rst),
        .key   (key_up),
        .pulse (up_pulse)
    );

    key_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_key_down (
        .clk   (clk),
        .rst   (rst),
        .key   (key_down),
        .pulse (down_pulse)
    );

    game_ctrl #(
        .TICK_CYCLES (TICK_CYCLES),
        .INIT_TICKS  (INIT_TICKS),
        .FALL_TICKS  (FALL_TICKS)
    ) u_game_ctrl (
        .clk         (clk),
        .rst         (rst),
        .down_pulse  (down_pulse),
        .trail_empty (trail_empty),
        .mode        (mode),
        .init        (init),
        .move        (move),
        .fall        (fall)
    );

    segment_walker u_segment_walker (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .right_pulse (right_pulse),
        .left_pulse  (left_pulse),
        .up_pulse    (up_pulse),
        .trail_empty (trail_empty),
        .display     (display)
    );

endmodule

/* tb_snake_top.sv */
module tb_snake_top;

    timeunit 1ns;
    timeprecision 1ps;

    import snake_pkg::*;

    localparam int TICK_CYCLES    = 8;
    localparam int INIT_TICKS     = 3;
    localparam int FALL_TICKS     = 1;
    localparam int DEBOUNCE_LEN   = 4;
    localparam int INIT_CYCLES    = INIT_TICKS * TICK_CYCLES;
    localparam int FALL_CYCLES    = FALL_TICKS * TICK_CYCLES;
    localparam int PRESS_CYCLES   = 12;
    localparam int RELEASE_CYCLES = 12;
    localparam int ROUNDS         = 2;
    localparam int ROUND_STEPS    = 15;
    localparam int N_STEPS        = ROUNDS * ROUND_STEPS;
    localparam int TIMEOUT_CYCLES = N_STEPS * (PRESS_CYCLES + RELEASE_CYCLES)
                                    + ROUNDS * (INIT_CYCLES + FALL_CYCLES) + 200;

    localparam segs_t SEGS_DARK = 7'h7f;

    typedef enum logic [1:0] {
        BTN_RIGHT = 2'd0,
        BTN_LEFT  = 2'd1,
        BTN_UP    = 2'd2,
        BTN_DOWN  = 2'd3
    } btn_e;

    typedef enum logic [1:0] {
        CHK_NONE      = 2'd0,
        CHK_INIT_MOVE = 2'd1,
        CHK_FALL_INIT = 2'd2
    } timing_e;

    typedef struct {
        btn_e    btn;
        segs_t   disp;
        mode_e   mode;
        timing_e timing;
        logic    gap;
    } step_t;

    logic  clk = 1'b0;
    logic  rst;
    logic  key_right;
    logic  key_left;
    logic  key_up;
    logic  key_down;
    segs_t display;
    logic  init;
    logic  move;
    logic  fall;

    step_t steps [N_STEPS];
    int    step_count = 0;
    int    seed       = 55624;
    int    cycle      = 0;
    int    init_cycle = -1;
    int    move_cycle = -1;
    int    dark_cycle = -1;
    logic  prev_init  = 1'b0;
    logic  prev_move  = 1'b0;
    logic  prev_dark  = 1'b0;

    snake_top #(
        .TICK_CYCLES  (TICK_CYCLES),
        .INIT_TICKS   (INIT_TICKS),
        .FALL_TICKS   (FALL_TICKS),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .key_right (key_right),
        .key_left  (key_left),
        .key_up    (key_up),
        .key_down  (key_down),
        .display   (display),
        .init      (init),
        .move      (move),
        .fall      (fall)
    );

    always #2 clk = ~clk;

    function automatic segs_t seg_bit(seg_e s);
        segs_t m;
        m = '0;
        m[s] = 1'b1;
        return m;
    endfunction

    // Active low mask with only s lit
    function automatic segs_t lit_only(seg_e s);
        return ~seg_bit(s);
    endfunction

    // Bit 0 is key_right, bit 3 is key_down
    function automatic logic [3:0] key_levels(btn_e btn);
        logic [3:0] levels;
        levels = 4'b0000;
        levels[btn] = 1'b1;
        return levels;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_display(input segs_t got, input segs_t expected);
        if (got !== expected) begin
            report_failure($sformatf("CHECK FAILED at time %0d ns: display %b, expected %b",
                $time, got, expected));
        end
    endtask

    task automatic check_mode(input mode_e expected);
        logic [2:0] want;
        case (expected)
            MODE_INIT: want = 3'b100;
            MODE_MOVE: want = 3'b010;
            default:   want = 3'b001;
        endcase
        if ({init, move, fall} !== want) begin
            report_failure($sformatf(
                "CHECK FAILED at time %0d ns: init/move/fall %b, expected %b (%s)",
                $time, {init, move, fall}, want, expected.name()));
        end
    endtask

    task automatic check_cycles(input int got, input int expected, input string what);
        if (got != expected) begin
            report_failure($sformatf(
                "CHECK FAILED at time %0d ns: %s took %0d cycles, expected %0d",
                $time, what, got, expected));
        end
    endtask

    task automatic add_step(input btn_e btn, input segs_t disp, input mode_e mode,
                            input timing_e timing, input logic gap);
        steps[step_count].btn    = btn;
        steps[step_count].disp   = disp;
        steps[step_count].mode   = mode;
        steps[step_count].timing = timing;
        steps[step_count].gap    = gap;
        step_count++;
    endtask

    // One game round from init with the walker on G heading left
    task automatic fill_round();
        segs_t dark;
        // Down is ignored while init runs out
        add_step(BTN_DOWN, lit_only(SEG_G), MODE_MOVE, CHK_INIT_MOVE, 1'b0);
        add_step(BTN_RIGHT, lit_only(SEG_F), MODE_MOVE, CHK_NONE, 1'b1);
        add_step(BTN_RIGHT, lit_only(SEG_A), MODE_MOVE, CHK_NONE, 1'b0);
        add_step(BTN_RIGHT, lit_only(SEG_B), MODE_MOVE, CHK_NONE, 1'b0);
        add_step(BTN_RIGHT, lit_only(SEG_G), MODE_MOVE, CHK_NONE, 1'b0);
        // No row for up at G heading left
        add_step(BTN_UP, lit_only(SEG_G), MODE_MOVE, CHK_NONE, 1'b0);
        dark = seg_bit(SEG_G);
        add_step(BTN_DOWN, dark, MODE_FALL, CHK_NONE, 1'b0);
        dark |= seg_bit(SEG_F);
        add_step(BTN_RIGHT, dark, MODE_FALL, CHK_NONE, 1'b0);
        add_step(BTN_DOWN, dark, MODE_FALL, CHK_NONE, 1'b0);
        dark |= seg_bit(SEG_A);
        add_step(BTN_RIGHT, dark, MODE_FALL, CHK_NONE, 1'b0);
        dark |= seg_bit(SEG_B);
        add_step(BTN_RIGHT, dark, MODE_FALL, CHK_NONE, 1'b0);
        // Back on G which is already dark
        add_step(BTN_RIGHT, dark, MODE_FALL, CHK_NONE, 1'b0);
        dark |= seg_bit(SEG_E);
        add_step(BTN_LEFT, dark, MODE_FALL, CHK_NONE, 1'b0);
        dark |= seg_bit(SEG_D);
        add_step(BTN_LEFT, dark, MODE_FALL, CHK_NONE, 1'b0);
        // C is the last one and init follows the hold
        add_step(BTN_LEFT, lit_only(SEG_G), MODE_INIT, CHK_FALL_INIT, 1'b0);
    endtask

    task press_and_release(input btn_e btn);
        @(posedge clk);
        {key_down, key_up, key_left, key_right} <= key_levels(btn);
        repeat (PRESS_CYCLES) @(posedge clk);
        {key_down, key_up, key_left, key_right} <= 4'b0000;
        repeat (RELEASE_CYCLES) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the test did not finish within %0d clock cycles",
                TIMEOUT_CYCLES));
        end
    end

    // Cycle stamps of mode entries and of the trail going dark
    always @(negedge clk) begin
        if (!rst) begin
            if (init && !prev_init) begin
                init_cycle = cycle;
            end
            if (move && !prev_move) begin
                move_cycle = cycle;
            end
            if (fall && (display == SEGS_DARK) && !prev_dark) begin
                dark_cycle = cycle;
            end
            prev_init = init;
            prev_move = move;
            prev_dark = fall && (display == SEGS_DARK);
        end
    end

    initial begin
        int i;
        int gap;
        rst <= 1'b1;
        {key_down, key_up, key_left, key_right} <= 4'b0000;
        fill_round();
        fill_round();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_mode(MODE_INIT);
        check_display(display, lit_only(SEG_G));
        for (i = 0; i < step_count; i++) begin
            if (steps[i].gap) begin
                gap = $random(seed) & 15;
                repeat (gap) @(posedge clk);
            end
            press_and_release(steps[i].btn);
            @(negedge clk);
            check_display(display, steps[i].disp);
            check_mode(steps[i].mode);
            if (steps[i].timing == CHK_INIT_MOVE) begin
                check_cycles(move_cycle - init_cycle, INIT_CYCLES, "init to move");
            end else if (steps[i].timing == CHK_FALL_INIT) begin
                check_cycles(init_cycle - dark_cycle, FALL_CYCLES, "empty trail to init");
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* flist.f */
snake_pkg.sv
key_pulse.sv
game_ctrl.sv
segment_walker.sv
snake_top.sv
tb_snake_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -j 0 --timescale 1ns/1ps -Wno-fatal -f flist.f --top-module tb_snake_top
	./obj_dir/Vtb_snake_top | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
